/* nlp_defines.svh */
// --------------------------------------------------
// frame, decimation and fixed-point size macros
// --------------------------------------------------
`ifndef NLP_DEFINES_SVH
`define NLP_DEFINES_SVH

// samples per frame
`define NLP_FRAME_LEN 16
// decimation step of the peak search
`define NLP_DEC 2
`define NLP_BINS (`NLP_FRAME_LEN / `NLP_DEC)

// Q16.16 words
`define NLP_DATA_W 32
`define NLP_FRAC_W 16

// buffer address width, enough for one frame
`define NLP_ADDR_W 4

`endif

/* nlp_pkg.sv */
// --------------------------------------------------
// shared types, Q16.16 constants and the
// fixed-point multiply
// --------------------------------------------------
`include "nlp_defines.svh"

package nlp_pkg;

	typedef logic signed [`NLP_DATA_W-1:0] sample_t;
	typedef logic [`NLP_ADDR_W-1:0] addr_t;
	typedef logic [$clog2(`NLP_BINS)-1:0] bin_t;

	// 0.95 and 1.0
	localparam sample_t notch_coeff = 32'sd62259;
	localparam sample_t one_q = 32'sd65536;

	// full product, arithmetic shift by the fraction bits, low word kept
	function automatic sample_t fxp_mul(input sample_t a, input sample_t b);
		logic signed [2*`NLP_DATA_W-1:0] prod;
		logic signed [2*`NLP_DATA_W-1:0] shifted;
		prod = a * b;
		shifted = prod >>> `NLP_FRAC_W;
		return shifted[`NLP_DATA_W-1:0];
	endfunction

endpackage

/* sq_bus_if.sv */
// --------------------------------------------------
// one requester port of the sample buffer bus
// --------------------------------------------------
`timescale 1ns/1ps

interface sq_bus_if;
	import nlp_pkg::*;

	// requester side
	logic req;
	logic we;
	addr_t addr;
	sample_t wdata;

	// arbiter side, gnt is combinational from req
	logic gnt;
	sample_t rdata;

	modport requester
	(
		output req,
		output we,
		output addr,
		output wdata,
		input gnt,
		input rdata
	);

	modport arbiter
	(
		input req,
		input we,
		input addr,
		input wdata,
		output gnt,
		output rdata
	);

endinterface

/* sq_buffer.sv */
// --------------------------------------------------
// single-port frame buffer, registered read
// --------------------------------------------------
`timescale 1ns/1ps
`include "nlp_defines.svh"

module sq_buffer
(
	input logic clk,
	input logic we,
	input nlp_pkg::addr_t addr,
	input nlp_pkg::sample_t wdata,
	output nlp_pkg::sample_t rdata
);
	import nlp_pkg::*;

	sample_t mem [`NLP_FRAME_LEN];

	// read returns the old word on a write cycle
	always_ff @(posedge clk)
	begin
		if (we)
		begin
			mem[addr] <= wdata;
		end
		rdata <= mem[addr];
	end

endmodule

/* sq_arbiter.sv */
// --------------------------------------------------
// fixed-priority arbiter for the buffer bus
// port 0 highest, port 2 lowest
// --------------------------------------------------
`timescale 1ns/1ps

module sq_arbiter
(
	sq_bus_if.arbiter sq [3],
	output logic mem_we,
	output nlp_pkg::addr_t mem_addr,
	output nlp_pkg::sample_t mem_wdata,
	input nlp_pkg::sample_t mem_rdata
);
	import nlp_pkg::*;

	localparam int n_req = 3;

	logic [n_req-1:0] req_vec;
	logic [n_req-1:0] gnt_vec;
	logic [n_req-1:0] we_vec;
	addr_t addr_arr [n_req];
	sample_t wdata_arr [n_req];

	// flatten the ports, read data goes back to all of them
	for (genvar i = 0; i < n_req; i++)
	begin : g_port
		assign req_vec[i] = sq[i].req;
		assign we_vec[i] = sq[i].we;
		assign addr_arr[i] = sq[i].addr;
		assign wdata_arr[i] = sq[i].wdata;
		assign sq[i].gnt = gnt_vec[i];
		assign sq[i].rdata = mem_rdata;
	end

	// lowest set request bit wins
	assign gnt_vec = req_vec & (~req_vec + 3'd1);

	always_comb
	begin
		mem_we = 1'b0;
		mem_addr = '0;
		mem_wdata = '0;
		for (int i = 0; i < n_req; i++)
		begin
			if (gnt_vec[i])
			begin
				mem_we = we_vec[i];
				mem_addr = addr_arr[i];
				mem_wdata = wdata_arr[i];
			end
		end
	end

endmodule

/* square_stage.sv */
// --------------------------------------------------
// sample input stage, writes each sample squared
// into the frame buffer
// --------------------------------------------------
`timescale 1ns/1ps
`include "nlp_defines.svh"

module square_stage
(
	input logic clk,
	input logic rst,
	input logic sample_valid,
	output logic sample_ready,
	input nlp_pkg::sample_t sample,
	input logic frame_release,
	output logic frame_done,
	sq_bus_if.requester bus
);
	import nlp_pkg::*;

	typedef enum logic [1:0] {s_accept, s_write, s_wait} state_t;

	state_t state;
	addr_t count;
	sample_t sq_data;
	logic last;

	assign last = (count == addr_t'(`NLP_FRAME_LEN - 1));
	assign sample_ready = (state == s_accept);

	assign bus.req = (state == s_write);
	assign bus.we = 1'b1;
	assign bus.addr = count;
	assign bus.wdata = sq_data;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state <= s_accept;
			count <= '0;
			frame_done <= 1'b0;
		end
		else
		begin
			frame_done <= 1'b0;
			case (state)
				s_accept:
				begin
					if (sample_valid)
					begin
						state <= s_write;
					end
				end
				s_write:
				begin
					if (bus.gnt)
					begin
						// counter wraps to 0 after the last sample
						count <= count + 1'b1;
						frame_done <= last;
						state <= last ? s_wait : s_accept;
					end
				end
				s_wait:
				begin
					// hold off the next frame until the result is taken
					if (frame_release)
					begin
						state <= s_accept;
					end
				end
				default:
				begin
					state <= s_accept;
				end
			endcase
		end
	end

	// squared sample, held while the write waits for the bus
	always_ff @(posedge clk)
	begin
		if (sample_valid && sample_ready)
		begin
			sq_data <= fxp_mul(sample, sample);
		end
	end

endmodule

/* notch_stage.sv */
// --------------------------------------------------
// DC notch filter, run in place over the buffer
// filter state carries from frame to frame
// --------------------------------------------------
`timescale 1ns/1ps
`include "nlp_defines.svh"

module notch_stage
(
	input logic clk,
	input logic rst,
	input logic start,
	output logic frame_done,
	sq_bus_if.requester bus
);
	import nlp_pkg::*;

	typedef enum logic [1:0] {s_idle, s_read, s_calc, s_write} state_t;

	state_t state;
	addr_t idx;
	sample_t mem_x;
	sample_t mem_y;
	sample_t notch;
	sample_t wr_data;
	logic last;

	assign last = (idx == addr_t'(`NLP_FRAME_LEN - 1));

	// x - mem_x + 0.95 * mem_y, with x on the bus read data
	assign notch = bus.rdata - mem_x + fxp_mul(notch_coeff, mem_y);

	assign bus.req = (state == s_read) || (state == s_write);
	assign bus.we = (state == s_write);
	assign bus.addr = idx;
	assign bus.wdata = wr_data;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state <= s_idle;
			idx <= '0;
			mem_x <= '0;
			mem_y <= '0;
			frame_done <= 1'b0;
		end
		else
		begin
			frame_done <= 1'b0;
			case (state)
				s_idle:
				begin
					if (start)
					begin
						idx <= '0;
						state <= s_read;
					end
				end
				s_read:
				begin
					if (bus.gnt)
					begin
						state <= s_calc;
					end
				end
				// read data is valid here, one cycle after the grant
				s_calc:
				begin
					mem_x <= bus.rdata;
					mem_y <= notch;
					state <= s_write;
				end
				s_write:
				begin
					if (bus.gnt)
					begin
						idx <= idx + 1'b1;
						frame_done <= last;
						state <= last ? s_idle : s_read;
					end
				end
				default:
				begin
					state <= s_idle;
				end
			endcase
		end
	end

	// filtered value plus the bias of one
	always_ff @(posedge clk)
	begin
		if (state == s_calc)
		begin
			wr_data <= notch + one_q;
		end
	end

endmodule

/* peak_search.sv */
// --------------------------------------------------
// decimated peak search and result handshake
// --------------------------------------------------
`timescale 1ns/1ps
`include "nlp_defines.svh"

module peak_search
(
	input logic clk,
	input logic rst,
	input logic start,
	output logic frame_release,
	output logic result_valid,
	input logic result_ready,
	output nlp_pkg::sample_t peak_value,
	output nlp_pkg::bin_t peak_bin,
	sq_bus_if.requester bus
);
	import nlp_pkg::*;

	typedef enum logic [1:0] {s_idle, s_read, s_cmp, s_result} state_t;

	state_t state;
	bin_t bin;

	assign bus.req = (state == s_read);
	assign bus.we = 1'b0;
	assign bus.addr = addr_t'(bin * `NLP_DEC);
	assign bus.wdata = '0;

	assign result_valid = (state == s_result);
	// frees the input stage in the same cycle the result is taken
	assign frame_release = result_valid && result_ready;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state <= s_idle;
			bin <= '0;
			peak_value <= '0;
			peak_bin <= '0;
		end
		else
		begin
			case (state)
				s_idle:
				begin
					if (start)
					begin
						bin <= '0;
						peak_value <= '0;
						peak_bin <= '0;
						state <= s_read;
					end
				end
				s_read:
				begin
					if (bus.gnt)
					begin
						state <= s_cmp;
					end
				end
				s_cmp:
				begin
					// strictly greater, so the first of equal peaks stays
					if (bus.rdata > peak_value)
					begin
						peak_value <= bus.rdata;
						peak_bin <= bin;
					end
					bin <= bin + 1'b1;
					state <= (bin == bin_t'(`NLP_BINS - 1)) ? s_result : s_read;
				end
				s_result:
				begin
					if (result_ready)
					begin
						state <= s_idle;
					end
				end
				default:
				begin
					state <= s_idle;
				end
			endcase
		end
	end

endmodule

/* nlp_front.sv */
// --------------------------------------------------
// pitch estimator front end: square, notch and
// peak stages sharing one frame buffer
// --------------------------------------------------
`timescale 1ns/1ps

module nlp_front
(
	input logic clk,
	input logic rst,
	input logic sample_valid,
	output logic sample_ready,
	input nlp_pkg::sample_t sample,
	output logic result_valid,
	input logic result_ready,
	output nlp_pkg::sample_t peak_value,
	output nlp_pkg::bin_t peak_bin
);
	import nlp_pkg::*;

	// bus ports in priority order: square, notch, peak
	sq_bus_if bus_if [3] ();

	logic square_done;
	logic notch_done;
	logic frame_release;

	logic mem_we;
	addr_t mem_addr;
	sample_t mem_wdata;
	sample_t mem_rdata;

	square_stage u_square
	(
		.clk(clk),
		.rst(rst),
		.sample_valid(sample_valid),
		.sample_ready(sample_ready),
		.sample(sample),
		.frame_release(frame_release),
		.frame_done(square_done),
		.bus(bus_if[0])
	);

	notch_stage u_notch
	(
		.clk(clk),
		.rst(rst),
		.start(square_done),
		.frame_done(notch_done),
		.bus(bus_if[1])
	);

	peak_search u_peak
	(
		.clk(clk),
		.rst(rst),
		.start(notch_done),
		.frame_release(frame_release),
		.result_valid(result_valid),
		.result_ready(result_ready),
		.peak_value(peak_value),
		.peak_bin(peak_bin),
		.bus(bus_if[2])
	);

	sq_arbiter u_arbiter
	(
		.sq(bus_if),
		.mem_we(mem_we),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_rdata(mem_rdata)
	);

	sq_buffer u_buffer
	(
		.clk(clk),
		.we(mem_we),
		.addr(mem_addr),
		.wdata(mem_wdata),
		.rdata(mem_rdata)
	);

endmodule

/* nlp_front_sva.sv */
// --------------------------------------------------
// concurrent checks on the nlp_front bus grants
// and result handshake
// --------------------------------------------------
`timescale 1ns/1ps

module nlp_front_sva
(
	input logic clk,
	input logic rst,
	input logic sample_ready,
	input logic result_valid,
	input logic result_ready,
	input nlp_pkg::sample_t peak_value,
	input nlp_pkg::bin_t peak_bin,
	input logic [2:0] req,
	input logic [2:0] gnt
);

	logic [2:0] exp_gnt;

	// priority order is square, notch, peak
	assign exp_gnt = req[0] ? 3'b001 : req[1] ? 3'b010 : req[2] ? 3'b100 : 3'b000;

	// at most one grant and it goes to the highest-priority request
	a_one_grant: assert property (@(posedge clk) disable iff (!rst)
		gnt == exp_gnt)
		else $error("buffer grant does not follow the request priority");

	// back-pressure: result held until taken
	a_result_hold: assert property (@(posedge clk) disable iff (!rst)
		(result_valid && !result_ready) |=>
		(result_valid && $stable(peak_value) && $stable(peak_bin)))
		else $error("result changed or dropped before result_ready");

	// input is closed while a result waits
	a_input_closed: assert property (@(posedge clk) disable iff (!rst)
		result_valid |-> !sample_ready)
		else $error("sample_ready high while result_valid is high");

endmodule

/* nlp_front_tb.sv */
// --------------------------------------------------
// testbench for nlp_front: pattern-driven frames,
// result handshake with random back-pressure
// --------------------------------------------------
`timescale 1ns/1ps
`include "nlp_defines.svh"

module nlp_front_tb;
	import nlp_pkg::*;

	localparam int n_frames = 2;
	localparam int words_per_frame = `NLP_FRAME_LEN + 2;
	localparam int reset_cycles = 16;
	// about 150 cycles per frame, wide margin
	localparam int frame_cycles = 150;
	localparam int cycle_limit = n_frames * frame_cycles * 13 + 100;

	logic clk;
	logic rst;
	logic sample_valid;
	logic sample_ready;
	sample_t sample;
	logic result_valid;
	logic result_ready;
	sample_t peak_value;
	bin_t peak_bin;

	logic [31:0] patterns [n_frames * words_per_frame];
	integer seed;
	int cycles = 0;
	int errors = 0;
	int test_errors = 0;
	int tests_run = 0;
	int tests_failed = 0;

	nlp_front UUT
	(
		.clk(clk),
		.rst(rst),
		.sample_valid(sample_valid),
		.sample_ready(sample_ready),
		.sample(sample),
		.result_valid(result_valid),
		.result_ready(result_ready),
		.peak_value(peak_value),
		.peak_bin(peak_bin)
	);

	bind nlp_front nlp_front_sva u_sva
	(
		.clk(clk),
		.rst(rst),
		.sample_ready(sample_ready),
		.result_valid(result_valid),
		.result_ready(result_ready),
		.peak_value(peak_value),
		.peak_bin(peak_bin),
		.req({bus_if[2].req, bus_if[1].req, bus_if[0].req}),
		.gnt({bus_if[2].gnt, bus_if[1].gnt, bus_if[0].gnt})
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// run limit
	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= cycle_limit)
		begin
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	task automatic log_error(input string msg);
		$display("Fail at %0t: %s", $time, msg);
		errors++;
		test_errors++;
	endtask

	task automatic close_test(input string name);
		tests_run++;
		if (test_errors == 0)
			$display("test %s: ok", name);
		else
		begin
			tests_failed++;
			$display("test %s: %0d errors", name, test_errors);
		end
		test_errors = 0;
	endtask

	// called on a falling edge, returns on the falling edge after the handshake
	task automatic send_sample(input sample_t value);
		sample_valid = 1'b1;
		sample = value;
		while (!sample_ready)
			@(negedge clk);
		@(negedge clk);
	endtask

	task automatic run_frame(input int frame);
		int base;
		int gap;
		int i;
		sample_t exp_value;
		bin_t exp_bin;
		sample_t held_value;
		bin_t held_bin;
		base = frame * words_per_frame;
		exp_value = patterns[base + `NLP_FRAME_LEN];
		exp_bin = bin_t'(patterns[base + `NLP_FRAME_LEN + 1]);
		for (i = 0; i < `NLP_FRAME_LEN; i++)
			send_sample(patterns[base + i]);

		// junk word offered while the input is closed
		sample = 32'sh7fff0000;
		sample_valid = 1'b1;
		while (!result_valid)
		begin
			if (sample_ready)
				log_error("sample_ready high before the result was taken");
			@(negedge clk);
		end

		// random back-pressure gap of at least one cycle
		held_value = peak_value;
		held_bin = peak_bin;
		gap = 1 + $unsigned($random(seed)) % 8;
		for (i = 0; i < gap; i++)
		begin
			@(negedge clk);
			if (!result_valid || peak_value !== held_value || peak_bin !== held_bin)
				log_error("result changed before result_ready");
			if (sample_ready)
				log_error("sample_ready high while the result waits");
		end

		if (peak_value !== exp_value)
			log_error($sformatf("frame %0d peak value %h, expected %h",
				frame + 1, peak_value, exp_value));
		if (peak_bin !== exp_bin)
			log_error($sformatf("frame %0d peak bin %0d, expected %0d",
				frame + 1, peak_bin, exp_bin));

		result_ready = 1'b1;
		@(negedge clk);
		result_ready = 1'b0;
		sample_valid = 1'b0;
		sample = '0;
		if (result_valid)
			log_error("result_valid still high after the result was taken");
		if (!sample_ready)
			log_error("sample_ready did not return after the result was taken");
	endtask

	initial
	begin
		rst = 1'b0;
		sample_valid = 1'b0;
		sample = '0;
		result_ready = 1'b0;
		seed = 32'h8c20d652;
		$readmemh("nlp_patterns.txt", patterns);

		repeat (reset_cycles) @(negedge clk);
		rst = 1'b1;
		@(negedge clk);
		if ($isunknown(patterns[n_frames * words_per_frame - 1]))
			log_error("pattern file nlp_patterns.txt could not be read");
		if (result_valid !== 1'b0)
			log_error("result_valid not low after reset");
		if (sample_ready !== 1'b1)
			log_error("sample_ready not high after reset");
		close_test("reset state");

		for (int f = 0; f < n_frames; f++)
		begin
			run_frame(f);
			close_test($sformatf("frame %0d", f + 1));
		end

		$display("tests: %0d run, %0d passed, %0d failed, %0d errors",
			tests_run, tests_run - tests_failed, tests_failed, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

/* nlp_front.f */
+incdir+.
nlp_pkg.sv
sq_bus_if.sv
sq_buffer.sv
sq_arbiter.sv
square_stage.sv
notch_stage.sv
peak_search.sv
nlp_front.sv
nlp_front_sva.sv
nlp_front_tb.sv

/* Makefile */
# Verilator build and run for the nlp_front testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := nlp_front_tb
FILELIST  := nlp_front.f
LOG       := sim.log
FAIL_MSG  := FAIL: see errors above

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

/* nlp_patterns.txt */
// one hex word per line: 16 Q16.16 samples per frame,
// then the expected peak value and peak bin of that frame
// frame 1, filter state starts at zero
00000100
FFFFFE00
00000300
00000000
00000200
FFFFFC00
00000100
00000000
00000300
00000200
FFFFFF00
00000400
00000000
00000200
FFFFFD00
00000100
00010007 1
// frame 2, filter state carried over from frame 1
00000200
00000000
FFFFFF00
00000300
00000400
00000100
00000000
FFFFFE00
00000100
00000400
00000200
FFFFFD00
00000000
00000100
00000300
00000200
00010007 2
